//--- knightPkg.sv
`default_nettype none

package knightPkg;

  ////////////////////
  // Data widths
  ////////////////////

  // Full command as assembled from two UART bytes
  typedef logic [15:0] cmdT;

  // One UART data byte
  typedef logic [7:0] byteT;

  // Motor speed, 0 is stopped and 15 is full speed
  typedef logic [3:0] speedT;

  // Number of squares to travel
  typedef logic [3:0] squareT;

  ////////////////////
  // Opcodes and responses
  ////////////////////

  // Opcode in bits 15 to 12 that requests a move
  localparam logic [3:0] opMove = 4'h4;

  // Byte returned when a move has finished
  localparam byteT respAck = 8'hA5;

  // Byte returned for any refused command
  localparam byteT respNack = 8'hEE;

endpackage

`default_nettype wire

//--- uartRx.sv
`default_nettype none

module uartRx #(
  parameter int BAUD_DIV = 16
) (
  input  logic            clk,
  input  logic            rstN,
  input  logic            rx,
  output knightPkg::byteT rxData,
  output logic            rxValid
);

  import knightPkg::*;

  localparam int CW = $clog2(BAUD_DIV);
  // Half a bit from the start edge, then one full bit per sample
  localparam logic [CW-1:0] HALF_BIT = CW'(BAUD_DIV / 2 - 1);
  localparam logic [CW-1:0] FULL_BIT = CW'(BAUD_DIV - 1);

  logic [1:0]    rxSync;
  logic          busy;
  logic [3:0]    bitCnt;
  logic [CW-1:0] baudCnt;
  byteT          shiftReg;

  assign rxData = shiftReg;

  // Data bits arrive LSB first
  always_ff @(posedge clk) begin
    if (!rstN) begin
      rxSync  <= 2'b11;
      busy    <= 1'b0;
      bitCnt  <= '0;
      baudCnt <= '0;
      rxValid <= 1'b0;
    end else begin
      // Two flop synchronizer on the serial line
      rxSync  <= {rxSync[0], rx};
      rxValid <= 1'b0;
      if (!busy) begin
        // Falling edge of the start bit
        if (!rxSync[1]) begin
          busy    <= 1'b1;
          bitCnt  <= '0;
          baudCnt <= HALF_BIT;
        end
      end else if (baudCnt != '0) begin
        baudCnt <= baudCnt - 1'b1;
      end else begin
        // Mid-bit sample point
        baudCnt <= FULL_BIT;
        bitCnt  <= bitCnt + 1'b1;
        if (bitCnt == 4'd0) begin
          // Line back high at mid start bit, treat as a glitch
          if (rxSync[1]) busy <= 1'b0;
        end else if (bitCnt == 4'd9) begin
          // Stop bit must be high or the frame is thrown away
          busy    <= 1'b0;
          rxValid <= rxSync[1];
        end else begin
          shiftReg <= {rxSync[1], shiftReg[7:1]};
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- cmdQueue.sv
`default_nettype none

module cmdQueue (
  input  logic            clk,
  input  logic            rstN,
  input  knightPkg::byteT rxData,
  input  logic            rxValid,
  output knightPkg::cmdT  cmd,
  output logic            cmdValid,
  input  logic            creditReturn
);

  import knightPkg::*;

  logic       lowPhase;
  byteT       hiByte;
  cmdT        fifoMem [2];
  logic       wrPtr;
  logic       rdPtr;
  logic [1:0] count;
  logic [1:0] creditCnt;
  logic       push;

  // Second byte completes a command, dropped when both entries are taken
  assign push = rxValid && lowPhase && (count != 2'd2);

  // One command per credit held
  assign cmdValid = (count != 2'd0) && (creditCnt != 2'd0);
  assign cmd      = fifoMem[rdPtr];

  ////////////////////
  // Byte pairing and storage
  ////////////////////
  always_ff @(posedge clk) begin
    if (push) fifoMem[wrPtr] <= {hiByte, rxData};
    if (rxValid && !lowPhase) hiByte <= rxData;
  end

  always_ff @(posedge clk) begin
    if (!rstN) begin
      lowPhase  <= 1'b0;
      wrPtr     <= 1'b0;
      rdPtr     <= 1'b0;
      count     <= 2'd0;
      creditCnt <= 2'd1;
    end else begin
      // High byte first, then low byte
      if (rxValid) lowPhase <= !lowPhase;
      if (push) wrPtr <= !wrPtr;
      if (cmdValid) rdPtr <= !rdPtr;
      case ({push, cmdValid})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      // Issue spends a credit, the executor hands it back when done
      case ({creditReturn, cmdValid})
        2'b10:   creditCnt <= creditCnt + 1'b1;
        2'b01:   creditCnt <= creditCnt - 1'b1;
        default: creditCnt <= creditCnt;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- moveExec.sv
`default_nettype none

module moveExec #(
  parameter int LINES_PER_SQUARE = 2
) (
  input  logic             clk,
  input  logic             rstN,
  input  knightPkg::cmdT   cmd,
  input  logic             cmdValid,
  output logic             creditReturn,
  input  logic             cntrIrN,
  output knightPkg::speedT speed [2],
  output logic             moving,
  output knightPkg::byteT  txData,
  output logic             txStart,
  input  logic             txBusy
);

  import knightPkg::*;

  // Wide enough for 15 squares worth of line crossings
  localparam int LW = $clog2(15 * LINES_PER_SQUARE + 1);

  typedef enum logic [1:0] {
    stIdle,
    stDrive,
    stRespond,
    stRelease
  } stateT;

  stateT         state;
  logic [2:0]    irSync;
  logic          lineFall;
  squareT        squares;
  logic [LW-1:0] lineCnt;
  logic [LW-1:0] lineTarget;
  logic [LW-1:0] nextCnt;

  assign squares = cmd[3:0];
  assign nextCnt = lineCnt + 1'b1;

  // Sensor is active low so a line shows up as a falling edge
  assign lineFall = irSync[2] && !irSync[1];

  assign moving       = (state == stDrive);
  assign txStart      = (state == stRespond) && !txBusy;
  assign creditReturn = (state == stRelease);

  ////////////////////
  // Command sequencing
  ////////////////////
  always_ff @(posedge clk) begin
    if (!rstN) begin
      state   <= stIdle;
      irSync  <= 3'b111;
      lineCnt <= '0;
      speed   <= '{default: '0};
    end else begin
      irSync <= {irSync[1:0], cntrIrN};
      case (state)
        stIdle: begin
          if (cmdValid) begin
            lineCnt    <= '0;
            lineTarget <= LW'(squares * LINES_PER_SQUARE);
            if (cmd[15:12] != opMove) begin
              // Refused without any motion
              txData <= respNack;
              state  <= stRespond;
            end else if (squares == '0) begin
              // Nothing to travel
              txData <= respAck;
              state  <= stRespond;
            end else begin
              speed[0] <= cmd[11:8];
              speed[1] <= cmd[7:4];
              state    <= stDrive;
            end
          end
        end
        stDrive: begin
          if (lineFall) begin
            lineCnt <= nextCnt;
            // Last crossing stops both motors
            if (nextCnt == lineTarget) begin
              speed  <= '{default: '0};
              txData <= respAck;
              state  <= stRespond;
            end
          end
        end
        // Wait for the transmitter to take the byte
        stRespond: if (!txBusy) state <= stRelease;
        default:   state <= stIdle;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- pwmChannel.sv
`default_nettype none

module pwmChannel #(
  parameter int PWM_STEPS = 15
) (
  input  logic             clk,
  input  logic             rstN,
  input  knightPkg::speedT speed,
  output logic             pwm1,
  output logic             pwm2
);

  import knightPkg::*;

  // Period counter, PWM_STEPS must not exceed 16
  speedT stepCnt;

  always_ff @(posedge clk) begin
    if (!rstN) begin
      stepCnt <= '0;
    end else if (stepCnt == speedT'(PWM_STEPS - 1)) begin
      stepCnt <= '0;
    end else begin
      stepCnt <= stepCnt + 1'b1;
    end
  end

  // High for speed steps out of every period
  assign pwm1 = (stepCnt < speed);

  // Complement of pwm1 but held low at standstill
  assign pwm2 = (speed != '0) && !pwm1;

endmodule

`default_nettype wire

//--- uartTx.sv
`default_nettype none

module uartTx #(
  parameter int BAUD_DIV = 16
) (
  input  logic            clk,
  input  logic            rstN,
  input  knightPkg::byteT txData,
  input  logic            txStart,
  output logic            tx,
  output logic            txBusy
);

  localparam int CW = $clog2(BAUD_DIV);
  localparam logic [CW-1:0] FULL_BIT = CW'(BAUD_DIV - 1);

  // Stop bit, data and start bit, shifted out from bit 0
  logic [9:0]    frame;
  logic [3:0]    bitCnt;
  logic [CW-1:0] baudCnt;

  // Frame is all ones while idle so the line rests high
  assign tx = frame[0];

  always_ff @(posedge clk) begin
    if (!rstN) begin
      frame   <= '1;
      txBusy  <= 1'b0;
      bitCnt  <= '0;
      baudCnt <= '0;
    end else if (!txBusy) begin
      if (txStart) begin
        frame   <= {1'b1, txData, 1'b0};
        txBusy  <= 1'b1;
        bitCnt  <= '0;
        baudCnt <= FULL_BIT;
      end
    end else if (baudCnt != '0) begin
      baudCnt <= baudCnt - 1'b1;
    end else begin
      // Bit period over, move to the next bit
      frame   <= {1'b1, frame[9:1]};
      baudCnt <= FULL_BIT;
      bitCnt  <= bitCnt + 1'b1;
      // Ten bits sent, end of stop bit
      if (bitCnt == 4'd9) txBusy <= 1'b0;
    end
  end

endmodule

`default_nettype wire

//--- knightCmd.sv
`default_nettype none

module knightCmd #(
  parameter int BAUD_DIV         = 16,
  parameter int PWM_STEPS        = 15,
  parameter int LINES_PER_SQUARE = 2
) (
  input  logic clk,
  input  logic rstN,
  input  logic rx,
  input  logic cntrIrN,
  output logic tx,
  output logic lftPwm1,
  output logic lftPwm2,
  output logic rghtPwm1,
  output logic rghtPwm2,
  output logic moving
);

  import knightPkg::*;

  byteT       rxData;
  logic       rxValid;
  cmdT        cmd;
  logic       cmdValid;
  logic       creditReturn;
  speedT      speed [2];
  byteT       txData;
  logic       txStart;
  logic       txBusy;
  logic [1:0] pwmA;
  logic [1:0] pwmB;

  ////////////////////
  // Command path
  ////////////////////
  uartRx #(.BAUD_DIV(BAUD_DIV)) iRx (
    .clk(clk), .rstN(rstN), .rx(rx), .rxData(rxData), .rxValid(rxValid)
  );

  cmdQueue iQueue (
    .clk(clk), .rstN(rstN), .rxData(rxData), .rxValid(rxValid),
    .cmd(cmd), .cmdValid(cmdValid), .creditReturn(creditReturn)
  );

  moveExec #(.LINES_PER_SQUARE(LINES_PER_SQUARE)) iExec (
    .clk(clk), .rstN(rstN), .cmd(cmd), .cmdValid(cmdValid),
    .creditReturn(creditReturn), .cntrIrN(cntrIrN), .speed(speed),
    .moving(moving), .txData(txData), .txStart(txStart), .txBusy(txBusy)
  );

  // Channel 0 drives the left motor, channel 1 the right
  for (genvar ch = 0; ch < 2; ch++) begin : gPwm
    pwmChannel #(.PWM_STEPS(PWM_STEPS)) iPwm (
      .clk(clk), .rstN(rstN), .speed(speed[ch]), .pwm1(pwmA[ch]), .pwm2(pwmB[ch])
    );
  end

  assign lftPwm1  = pwmA[0];
  assign lftPwm2  = pwmB[0];
  assign rghtPwm1 = pwmA[1];
  assign rghtPwm2 = pwmB[1];

  // Response byte back to the remote
  uartTx #(.BAUD_DIV(BAUD_DIV)) iTx (
    .clk(clk), .rstN(rstN), .txData(txData), .txStart(txStart), .tx(tx), .txBusy(txBusy)
  );

endmodule

`default_nettype wire

//--- tbClock.sv
`default_nettype none

module tbClock #(
  parameter int PERIOD = 40
) (
  output logic clk
);

  // Free running clock, first rising edge half a period in
  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

endmodule

`default_nettype wire

//--- knightCmd_assertions.sv
`default_nettype none

module queueAssertions (
  input logic       clk,
  input logic       rstN,
  input logic       cmdValid,
  input logic       creditReturn,
  input logic [1:0] creditCnt
);

  // Number of assertion failures so far
  int failCount = 0;

  // High from an issue until the executor hands the credit back
  logic inFlight;

  always_ff @(posedge clk) begin
    if (!rstN) begin
      inFlight <= 1'b0;
    end else if (cmdValid) begin
      inFlight <= 1'b1;
    end else if (creditReturn) begin
      inFlight <= 1'b0;
    end
  end

  // Issue strobe lasts one cycle
  issueOnePulse: assert property (@(posedge clk) disable iff (!rstN) cmdValid |=> !cmdValid)
    else begin
      $error("cmdValid stayed high for more than one cycle");
      failCount++;
    end

  // No second issue before the credit of the first has come back
  issueNeedsCredit: assert property (
    @(posedge clk) disable iff (!rstN) cmdValid |-> !inFlight
  ) else begin
    $error("cmdValid raised while no credit was held");
    failCount++;
  end

  // Only one command may be in flight
  creditBound: assert property (@(posedge clk) disable iff (!rstN) creditCnt <= 2'd1)
    else begin
      $error("Credit counter went above 1");
      failCount++;
    end

endmodule

bind cmdQueue queueAssertions qChk (
  .clk(clk), .rstN(rstN), .cmdValid(cmdValid), .creditReturn(creditReturn),
  .creditCnt(creditCnt)
);

`default_nettype wire

//--- knightCmdTb.sv
`default_nettype none

module knightCmdTb;

  import knightPkg::*;

  localparam int BAUD_DIV         = 16;
  localparam int PWM_STEPS        = 15;
  localparam int LINES_PER_SQUARE = 2;
  localparam int GAP_MIN          = 48;
  localparam int GAP_SPAN         = 50;
  // Two frames in, one out, and four squares of IR pulses at the longest gap
  localparam int CMD_CYCLES = 30 * BAUD_DIV + 4 * LINES_PER_SQUARE * (GAP_MIN + GAP_SPAN + 8);
  // Fifteen commands over all tests
  localparam int TIMEOUT_CYCLES = 15 * CMD_CYCLES + 500;

  logic clk;
  logic rstN, rx, cntrIrN, tx, moving;
  logic lftPwm1, lftPwm2, rghtPwm1, rghtPwm2;
  byteT respQ [$];
  int   errCount = 0;
  int   frameErrs = 0;
  int   pulseCnt = 0;
  int   framesStarted = 0;
  int   framesAtRise = 0;
  int   testCnt = 0;
  int   failedCnt = 0;

  tbClock #(.PERIOD(40)) clkGen (.clk(clk));

  knightCmd #(
    .BAUD_DIV(BAUD_DIV), .PWM_STEPS(PWM_STEPS), .LINES_PER_SQUARE(LINES_PER_SQUARE)
  ) dut (
    .clk(clk), .rstN(rstN), .rx(rx), .cntrIrN(cntrIrN), .tx(tx), .lftPwm1(lftPwm1),
    .lftPwm2(lftPwm2), .rghtPwm1(rghtPwm1), .rghtPwm2(rghtPwm2), .moving(moving)
  );

  ////////////////////
  // Reference model
  ////////////////////
  function automatic byteT expectResp(input cmdT c);
    return (c[15:12] == 4'h4) ? 8'hA5 : 8'hEE;
  endfunction

  // Only a move with a nonzero square count drives the motors
  function automatic bit expectMotion(input cmdT c);
    return (c[15:12] == 4'h4) && (c[3:0] != 4'h0);
  endfunction

  // High steps per PWM period saturate at the full period
  function automatic int expectHigh(input speedT s);
    return (int'(s) < PWM_STEPS) ? int'(s) : PWM_STEPS;
  endfunction

  // Complementary output fills the rest of the period but rests at speed 0
  function automatic int expectComplHigh(input speedT s);
    return (s == 4'h0) ? 0 : PWM_STEPS - expectHigh(s);
  endfunction

  // Kind 0 is a move, 1 a refused opcode, 2 a move of zero squares
  function automatic cmdT randomCmd(input int kind);
    logic [3:0] op;
    op = 4'($urandom_range(14));
    if (op >= 4'h4) op = op + 4'h1;
    case (kind)
      0:       return {4'h4, 4'($urandom), 4'($urandom), 4'(1 + $urandom_range(3))};
      1:       return {op, 4'($urandom), 4'($urandom), 4'($urandom)};
      default: return {4'h4, 4'($urandom), 4'($urandom), 4'h0};
    endcase
  endfunction

  ////////////////////
  // Checks and drivers
  ////////////////////
  task automatic checkEq(input string name, input logic [15:0] got, input logic [15:0] exp);
    assert (got === exp) else begin
      $display("** Error: %s = 0x%h, expected 0x%h at %0t", name, got, exp, $time);
      errCount++;
    end
  endtask

  // Start bit, data LSB first, stop bit
  task automatic sendByte(input byteT b);
    logic [9:0] frame;
    frame = {1'b1, b, 1'b0};
    for (int i = 0; i < 10; i++) begin
      rx = frame[i];
      repeat (BAUD_DIV) @(negedge clk);
    end
  endtask

  task automatic sendCmd(input cmdT c);
    sendByte(c[15:8]);
    sendByte(c[7:0]);
  endtask

  task automatic checkMotion(input cmdT c);
    int hiL;
    int hiR;
    int hiL2;
    int hiR2;
    int pulsesAtRise;
    hiL = 0;
    hiR = 0;
    hiL2 = 0;
    hiR2 = 0;
    while (!moving) @(negedge clk);
    pulsesAtRise = pulseCnt;
    framesAtRise = framesStarted;
    // Any full period holds exactly speed high steps
    for (int i = 0; i < PWM_STEPS; i++) begin
      hiL += int'(lftPwm1);
      hiR += int'(rghtPwm1);
      hiL2 += int'(lftPwm2);
      hiR2 += int'(rghtPwm2);
      checkEq("lftPwm1 & lftPwm2", 16'(lftPwm1 & lftPwm2), 16'h0);
      checkEq("rghtPwm1 & rghtPwm2", 16'(rghtPwm1 & rghtPwm2), 16'h0);
      @(negedge clk);
    end
    checkEq("lftPwm1 high steps", 16'(hiL), 16'(expectHigh(c[11:8])));
    checkEq("rghtPwm1 high steps", 16'(hiR), 16'(expectHigh(c[7:4])));
    checkEq("lftPwm2 high steps", 16'(hiL2), 16'(expectComplHigh(c[11:8])));
    checkEq("rghtPwm2 high steps", 16'(hiR2), 16'(expectComplHigh(c[7:4])));
    while (moving) @(negedge clk);
    checkEq("IR pulses", 16'(pulseCnt - pulsesAtRise), 16'(int'(c[3:0]) * LINES_PER_SQUARE));
    checkEq("PWM outputs", 16'({lftPwm1, lftPwm2, rghtPwm1, rghtPwm2}), 16'h0);
  endtask

  // Motors must rest while waiting for the response byte
  task automatic checkResp(input cmdT c);
    byteT got;
    while (respQ.size() == 0) begin
      checkEq("moving", 16'(moving), 16'h0);
      checkEq("PWM outputs", 16'({lftPwm1, lftPwm2, rghtPwm1, rghtPwm2}), 16'h0);
      @(negedge clk);
    end
    got = respQ.pop_front();
    checkEq("response byte", 16'(got), 16'(expectResp(c)));
  endtask

  task automatic runCommand(input cmdT c);
    sendCmd(c);
    if (expectMotion(c)) checkMotion(c);
    checkResp(c);
  endtask

  task automatic finishTest(input string name, input int errsBefore);
    testCnt++;
    if (errCount == errsBefore) begin
      $display("Test %0d %s: passed", testCnt, name);
    end else begin
      failedCnt++;
      $display("Test %0d %s: failed with %0d errors", testCnt, name, errCount - errsBefore);
    end
  endtask

  ////////////////////
  // Background processes
  ////////////////////
  // Line pulses at random gaps and only while the robot moves
  initial begin : irPulser
    cntrIrN = 1'b1;
    forever begin
      @(negedge clk);
      if (moving) begin
        repeat (GAP_MIN + $urandom_range(GAP_SPAN)) @(negedge clk);
        if (moving) begin
          cntrIrN = 1'b0;
          pulseCnt++;
          repeat (2 + $urandom_range(3)) @(negedge clk);
          cntrIrN = 1'b1;
        end
      end
    end
  end

  // Samples each response bit in its middle
  initial begin : uartMonitor
    byteT b;
    forever begin
      @(negedge clk);
      if (rstN && !tx) begin
        framesStarted++;
        repeat (BAUD_DIV / 2) @(negedge clk);
        for (int i = 0; i < 8; i++) begin
          repeat (BAUD_DIV) @(negedge clk);
          b[i] = tx;
        end
        repeat (BAUD_DIV) @(negedge clk);
        assert (tx) else begin
          $display("Response frame ended with a low stop bit at %0t", $time);
          frameErrs++;
        end
        respQ.push_back(b);
      end
    end
  end

  initial begin : watchdog
    repeat (TIMEOUT_CYCLES) @(posedge clk);
    $display("Run did not finish within %0d cycles, a motion or response never came",
             TIMEOUT_CYCLES);
    $display("=== FAIL ===");
    $finish;
  end

  ////////////////////
  // Test sequence
  ////////////////////
  initial begin : mainSeq
    cmdT a;
    cmdT b;
    int  errsBefore;
    int  framesBefore;
    void'($urandom(32'h55ea_0acf));
    rstN = 1'b0;
    rx   = 1'b1;
    repeat (3) @(negedge clk);
    rstN = 1'b1;
    @(negedge clk);

    errsBefore = errCount;
    checkEq("tx", 16'(tx), 16'h1);
    checkEq("PWM outputs", 16'({lftPwm1, lftPwm2, rghtPwm1, rghtPwm2}), 16'h0);
    checkEq("moving", 16'(moving), 16'h0);
    finishTest("reset state", errsBefore);

    errsBefore = errCount;
    runCommand(randomCmd(0));
    finishTest("single move", errsBefore);

    errsBefore = errCount;
    runCommand(randomCmd(1));
    finishTest("refused opcode", errsBefore);

    errsBefore = errCount;
    runCommand(randomCmd(2));
    finishTest("zero squares", errsBefore);

    // Long first move so the second command lands while it runs
    errsBefore = errCount;
    a = {4'h4, 4'($urandom), 4'($urandom), 4'h4};
    b = randomCmd(0);
    framesBefore = framesStarted;
    sendCmd(a);
    fork
      begin
        sendCmd(b);
        assert (moving) else begin
          $display("First move ended before the second command was received");
          errCount++;
        end
      end
      checkMotion(a);
    join
    checkMotion(b);
    checkEq("frames before second move", 16'(framesAtRise - framesBefore), 16'h1);
    checkResp(a);
    checkResp(b);
    finishTest("back-to-back moves", errsBefore);

    errsBefore = errCount;
    for (int i = 0; i < 10; i++) runCommand(randomCmd($urandom_range(2)));
    finishTest("random commands", errsBefore);

    errCount += frameErrs + dut.iQueue.qChk.failCount;
    $display("Tests: %0d run, %0d failed, %0d errors", testCnt, failedCnt, errCount);
    if (errCount == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tb.f
knightPkg.sv
uartRx.sv
cmdQueue.sv
moveExec.sv
pwmChannel.sv
uartTx.sv
knightCmd.sv
tbClock.sv
knightCmd_assertions.sv
knightCmdTb.sv

//--- Makefile
# Verilator build and run of the knight command testbench

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module knightCmdTb -f tb.f -Mdir obj_dir
	@out="$$(./obj_dir/VknightCmdTb)"; echo "$$out"; echo "$$out" | grep -q "=== PASS ==="

clean:
	rm -rf obj_dir
